// File: common/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

`define BUS_ADDR_W      32
`define BUS_DATA_W      32
`define BUS_BEAT_BYTES  4        // address step between beats of an INCR burst.

// the timer answers when address bits 31..16 hold this value.
`define CLINT_BASE_HI   16'h0200
`define CLINT_MTIME_LO  16'hBFF8
`define CLINT_MTIME_HI  16'hBFFC

`define AXI_BURST_INCR  2'b01
`define AXI_RESP_OKAY   2'b00

`endif

// File: common/bus_pkg.sv
`include "bus_defines.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0]     bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0]     bus_data_t;
    typedef logic [`BUS_BEAT_BYTES-1:0] bus_strb_t;

    typedef logic [7:0] bus_len_t;      // beats minus one.
    typedef logic [2:0] bus_size_t;
    typedef logic [1:0] bus_burst_t;
    typedef logic [1:0] bus_resp_t;

    typedef logic [63:0] mtime_t;

    typedef enum logic {
        own_fetch,
        own_lsu
    } rd_owner_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_grant,
        arb_busy
    } arb_state_e;

endpackage

// File: common/rd_req_if.sv
interface rd_req_if import bus_pkg::*; ();

    logic       valid;
    logic       ready;
    bus_addr_t  addr;
    bus_len_t   len;
    bus_size_t  size;
    bus_burst_t burst;

    modport requester (
        output valid, addr, len, size, burst,
        input  ready
    );

    // valid and the fields hold until the edge where ready is seen high.
    modport responder (
        input  valid, addr, len, size, burst,
        output ready
    );

endinterface

// File: common/rd_rsp_if.sv
interface rd_rsp_if import bus_pkg::*; ();

    logic      valid;
    logic      ready;
    bus_data_t data;
    bus_resp_t resp;
    logic      last;

    modport responder (
        output valid, data, resp, last,
        input  ready
    );

    modport receiver (
        input  valid, data, resp, last,
        output ready
    );

endinterface

// File: hw/clint/clint_timer.sv
`include "bus_defines.svh"

module clint_timer import bus_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    rd_req_if.responder req,
    rd_rsp_if.responder rsp
);

    mtime_t    mtime;
    bus_data_t rd_half;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_comb begin
        case (req.addr[15:0])
            `CLINT_MTIME_LO: rd_half = mtime[31:0];
            `CLINT_MTIME_HI: rd_half = mtime[63:32];
            default:         rd_half = '0;    // other offsets are not mapped.
        endcase
    end

    assign req.ready = !rsp.valid || rsp.ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end else if (req.valid && req.ready) begin
            rsp.valid <= 1'b1;
        end else if (rsp.ready) begin
            rsp.valid <= 1'b0;
        end
    end

    // value sampled at the request edge, held until the beat is taken.
    always_ff @(posedge clock) begin
        if (req.valid && req.ready) begin
            rsp.data <= rd_half;
        end
    end

    assign rsp.resp = `AXI_RESP_OKAY;
    assign rsp.last = 1'b1;

endmodule

// File: hw/core_bus_top.sv
`include "bus_defines.svh"

module core_bus_top import bus_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,

    input  logic       fetch_arvalid,
    output logic       fetch_arready,
    input  bus_addr_t  fetch_araddr,
    input  bus_len_t   fetch_arlen,
    input  bus_size_t  fetch_arsize,
    input  bus_burst_t fetch_arburst,
    output logic       fetch_rvalid,
    input  logic       fetch_rready,
    output bus_data_t  fetch_rdata,
    output bus_resp_t  fetch_rresp,
    output logic       fetch_rlast,

    input  logic       lsu_arvalid,
    output logic       lsu_arready,
    input  bus_addr_t  lsu_araddr,
    input  bus_size_t  lsu_arsize,
    output logic       lsu_rvalid,
    input  logic       lsu_rready,
    output bus_data_t  lsu_rdata,
    output bus_resp_t  lsu_rresp,
    output logic       lsu_rlast,

    input  logic       lsu_awvalid,
    output logic       lsu_awready,
    input  bus_addr_t  lsu_awaddr,
    input  bus_size_t  lsu_awsize,
    input  logic       lsu_wvalid,
    output logic       lsu_wready,
    input  bus_data_t  lsu_wdata,
    input  bus_strb_t  lsu_wstrb,
    output logic       lsu_bvalid,
    input  logic       lsu_bready,
    output bus_resp_t  lsu_bresp,

    output logic       m_axi_arvalid,
    input  logic       m_axi_arready,
    output bus_addr_t  m_axi_araddr,
    output bus_len_t   m_axi_arlen,
    output bus_size_t  m_axi_arsize,
    output bus_burst_t m_axi_arburst,
    input  logic       m_axi_rvalid,
    output logic       m_axi_rready,
    input  bus_data_t  m_axi_rdata,
    input  bus_resp_t  m_axi_rresp,
    input  logic       m_axi_rlast,

    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output bus_addr_t  m_axi_awaddr,
    output bus_size_t  m_axi_awsize,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    output bus_data_t  m_axi_wdata,
    output bus_strb_t  m_axi_wstrb,
    output logic       m_axi_wlast,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    input  bus_resp_t  m_axi_bresp
);

    rd_req_if fetch_req ();
    rd_req_if lsu_req ();
    rd_req_if gnt_req ();
    rd_req_if clint_req ();
    rd_rsp_if clint_rsp ();
    rd_rsp_if fetch_rsp ();
    rd_rsp_if lsu_rsp ();

    logic      read_done;
    rd_owner_e owner;

    assign fetch_req.valid = fetch_arvalid;
    assign fetch_req.addr  = fetch_araddr;
    assign fetch_req.len   = fetch_arlen;
    assign fetch_req.size  = fetch_arsize;
    assign fetch_req.burst = fetch_arburst;
    assign fetch_arready   = fetch_req.ready;

    // the load side only sends single beats.
    assign lsu_req.valid = lsu_arvalid;
    assign lsu_req.addr  = lsu_araddr;
    assign lsu_req.len   = '0;
    assign lsu_req.size  = lsu_arsize;
    assign lsu_req.burst = `AXI_BURST_INCR;
    assign lsu_arready   = lsu_req.ready;

    assign fetch_rvalid    = fetch_rsp.valid;
    assign fetch_rdata     = fetch_rsp.data;
    assign fetch_rresp     = fetch_rsp.resp;
    assign fetch_rlast     = fetch_rsp.last;
    assign fetch_rsp.ready = fetch_rready;

    assign lsu_rvalid    = lsu_rsp.valid;
    assign lsu_rdata     = lsu_rsp.data;
    assign lsu_rresp     = lsu_rsp.resp;
    assign lsu_rlast     = lsu_rsp.last;
    assign lsu_rsp.ready = lsu_rready;

    read_arbiter read_arbiter_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .fetch     (fetch_req.responder),
        .lsu       (lsu_req.responder),
        .gnt       (gnt_req.requester),
        .read_done (read_done),
        .owner     (owner)
    );

    read_router read_router_i (
        .gnt           (gnt_req.responder),
        .owner         (owner),
        .read_done     (read_done),
        .clint_req     (clint_req.requester),
        .clint_rsp     (clint_rsp.receiver),
        .fetch_rsp     (fetch_rsp.responder),
        .lsu_rsp       (lsu_rsp.responder),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arlen   (m_axi_arlen),
        .m_axi_arsize  (m_axi_arsize),
        .m_axi_arburst (m_axi_arburst),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rlast   (m_axi_rlast)
    );

    clint_timer clint_timer_i (
        .clock (clock),
        .rst_n (rst_n),
        .req   (clint_req.responder),
        .rsp   (clint_rsp.responder)
    );

    write_channel write_channel_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .lsu_awvalid   (lsu_awvalid),
        .lsu_awready   (lsu_awready),
        .lsu_awaddr    (lsu_awaddr),
        .lsu_awsize    (lsu_awsize),
        .lsu_wvalid    (lsu_wvalid),
        .lsu_wready    (lsu_wready),
        .lsu_wdata     (lsu_wdata),
        .lsu_wstrb     (lsu_wstrb),
        .lsu_bvalid    (lsu_bvalid),
        .lsu_bready    (lsu_bready),
        .lsu_bresp     (lsu_bresp),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awsize  (m_axi_awsize),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wlast   (m_axi_wlast),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready),
        .m_axi_bresp   (m_axi_bresp)
    );

endmodule

// File: hw/read_arbiter.sv
module read_arbiter import bus_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    rd_req_if.responder fetch,
    rd_req_if.responder lsu,
    rd_req_if.requester gnt,
    input  logic        read_done,
    output rd_owner_e   owner
);

    arb_state_e state;
    rd_owner_e  last_winner;
    rd_owner_e  winner;
    logic       any_valid;
    logic       owner_valid;

    bus_addr_t  addr_q;
    bus_len_t   len_q;
    bus_size_t  size_q;
    bus_burst_t burst_q;

    assign any_valid = fetch.valid || lsu.valid;

    // with both waiting, the side that lost last time goes first.
    always_comb begin
        if (fetch.valid && lsu.valid) begin
            winner = (last_winner == own_fetch) ? own_lsu : own_fetch;
        end else if (fetch.valid) begin
            winner = own_fetch;
        end else begin
            winner = own_lsu;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= arb_idle;
            last_winner <= own_lsu;    // so that fetch wins the first round.
        end else begin
            case (state)
                arb_idle: begin
                    if (any_valid) begin
                        state       <= arb_grant;
                        last_winner <= winner;
                    end
                end
                arb_grant: begin
                    if (gnt.valid && gnt.ready) begin
                        state <= arb_busy;
                    end
                end
                arb_busy: begin
                    if (read_done) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // The fields are kept until the next grant, so the router can still look at the
    // address while the data comes back.
    always_ff @(posedge clock) begin
        if (state == arb_idle && any_valid) begin
            addr_q  <= (winner == own_fetch) ? fetch.addr  : lsu.addr;
            len_q   <= (winner == own_fetch) ? fetch.len   : lsu.len;
            size_q  <= (winner == own_fetch) ? fetch.size  : lsu.size;
            burst_q <= (winner == own_fetch) ? fetch.burst : lsu.burst;
        end
    end

    assign owner       = last_winner;
    assign owner_valid = (last_winner == own_fetch) ? fetch.valid : lsu.valid;

    assign gnt.valid = (state == arb_grant) && owner_valid;
    assign gnt.addr  = addr_q;
    assign gnt.len   = len_q;
    assign gnt.size  = size_q;
    assign gnt.burst = burst_q;

    assign fetch.ready = (state == arb_grant) && (last_winner == own_fetch) && gnt.ready;
    assign lsu.ready   = (state == arb_grant) && (last_winner == own_lsu) && gnt.ready;

endmodule

// File: hw/read_router.sv
`include "bus_defines.svh"

module read_router import bus_pkg::*; (
    rd_req_if.responder gnt,
    input  rd_owner_e   owner,
    output logic        read_done,

    rd_req_if.requester clint_req,
    rd_rsp_if.receiver  clint_rsp,

    rd_rsp_if.responder fetch_rsp,
    rd_rsp_if.responder lsu_rsp,

    output logic        m_axi_arvalid,
    input  logic        m_axi_arready,
    output bus_addr_t   m_axi_araddr,
    output bus_len_t    m_axi_arlen,
    output bus_size_t   m_axi_arsize,
    output bus_burst_t  m_axi_arburst,

    input  logic        m_axi_rvalid,
    output logic        m_axi_rready,
    input  bus_data_t   m_axi_rdata,
    input  bus_resp_t   m_axi_rresp,
    input  logic        m_axi_rlast
);

    logic      is_clint;
    logic      src_valid;
    bus_data_t src_data;
    bus_resp_t src_resp;
    logic      src_last;
    logic      owner_ready;

    // The granted address stays put until the next grant, so this one test also picks
    // the source of the returning beats.
    assign is_clint = (gnt.addr[`BUS_ADDR_W-1:16] == `CLINT_BASE_HI);

    assign clint_req.valid = gnt.valid && is_clint;
    assign clint_req.addr  = gnt.addr;
    assign clint_req.len   = gnt.len;
    assign clint_req.size  = gnt.size;
    assign clint_req.burst = gnt.burst;

    assign m_axi_arvalid = gnt.valid && !is_clint;
    assign m_axi_araddr  = gnt.addr;
    assign m_axi_arlen   = gnt.len;
    assign m_axi_arsize  = gnt.size;
    assign m_axi_arburst = gnt.burst;

    assign gnt.ready = is_clint ? clint_req.ready : m_axi_arready;

    assign src_valid = is_clint ? clint_rsp.valid : m_axi_rvalid;
    assign src_data  = is_clint ? clint_rsp.data  : m_axi_rdata;
    assign src_resp  = is_clint ? clint_rsp.resp  : m_axi_rresp;
    assign src_last  = is_clint ? clint_rsp.last  : m_axi_rlast;

    assign owner_ready = (owner == own_fetch) ? fetch_rsp.ready : lsu_rsp.ready;

    assign m_axi_rready    = !is_clint && owner_ready;    // back-pressure goes straight through.
    assign clint_rsp.ready = is_clint && owner_ready;

    assign fetch_rsp.valid = src_valid && (owner == own_fetch);
    assign fetch_rsp.data  = src_data;
    assign fetch_rsp.resp  = src_resp;
    assign fetch_rsp.last  = src_last;

    assign lsu_rsp.valid = src_valid && (owner == own_lsu);
    assign lsu_rsp.data  = src_data;
    assign lsu_rsp.resp  = src_resp;
    assign lsu_rsp.last  = src_last;

    assign read_done = src_valid && owner_ready && src_last;

endmodule

// File: hw/write_channel.sv
module write_channel import bus_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    input  logic      lsu_awvalid,
    output logic      lsu_awready,
    input  bus_addr_t lsu_awaddr,
    input  bus_size_t lsu_awsize,
    input  logic      lsu_wvalid,
    output logic      lsu_wready,
    input  bus_data_t lsu_wdata,
    input  bus_strb_t lsu_wstrb,
    output logic      lsu_bvalid,
    input  logic      lsu_bready,
    output bus_resp_t lsu_bresp,

    output logic      m_axi_awvalid,
    input  logic      m_axi_awready,
    output bus_addr_t m_axi_awaddr,
    output bus_size_t m_axi_awsize,
    output logic      m_axi_wvalid,
    input  logic      m_axi_wready,
    output bus_data_t m_axi_wdata,
    output bus_strb_t m_axi_wstrb,
    output logic      m_axi_wlast,
    input  logic      m_axi_bvalid,
    output logic      m_axi_bready,
    input  bus_resp_t m_axi_bresp
);

    logic aw_sent;
    logic w_sent;

    // each flag closes its channel until the write response comes back.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (m_axi_bvalid && m_axi_bready) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (m_axi_awvalid && m_axi_awready) aw_sent <= 1'b1;
            if (m_axi_wvalid && m_axi_wready) w_sent <= 1'b1;
        end
    end

    assign m_axi_awvalid = lsu_awvalid && !aw_sent;
    assign lsu_awready   = m_axi_awready && !aw_sent;
    assign m_axi_awaddr  = lsu_awaddr;
    assign m_axi_awsize  = lsu_awsize;

    assign m_axi_wvalid = lsu_wvalid && !w_sent;
    assign lsu_wready   = m_axi_wready && !w_sent;
    assign m_axi_wdata  = lsu_wdata;
    assign m_axi_wstrb  = lsu_wstrb;
    assign m_axi_wlast  = 1'b1;    // single beat writes only.

    assign lsu_bvalid   = m_axi_bvalid;
    assign lsu_bresp    = m_axi_bresp;
    assign m_axi_bready = lsu_bready;

endmodule

// File: verification/core_bus_properties.sv
module core_bus_properties import bus_pkg::*; (
    input logic       clock,
    input logic       rst_n,
    input logic       m_axi_arvalid,
    input logic       m_axi_arready,
    input bus_addr_t  m_axi_araddr,
    input bus_len_t   m_axi_arlen,
    input bus_size_t  m_axi_arsize,
    input bus_burst_t m_axi_arburst,
    input logic       m_axi_rvalid,
    input logic       m_axi_rready,
    input logic       m_axi_rlast,
    input logic       m_axi_awvalid,
    input logic       m_axi_awready,
    input logic       m_axi_wvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic ar_open;    // an AR was accepted and its last beat is still to come.

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ar_open <= 1'b0;
        end else if (m_axi_arvalid && m_axi_arready) begin
            ar_open <= 1'b1;
        end else if (m_axi_rvalid && m_axi_rready && m_axi_rlast) begin
            ar_open <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr)
            && $stable(m_axi_arlen) && $stable(m_axi_arsize) && $stable(m_axi_arburst))
        else $error("AR changed before its handshake");

    ar_single: assert property (@(posedge clock) disable iff (!rst_n)
        ar_open |-> !m_axi_arvalid)
        else $error("new AR while a read is in flight");

    aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid)
        else $error("AW valid dropped before its handshake");

    reset_quiet: assert property (@(posedge clock)
        !rst_n |-> !m_axi_arvalid && !m_axi_awvalid && !m_axi_wvalid)
        else $error("valid high during reset");

endmodule

bind core_bus_top core_bus_properties core_bus_properties_i (.*);

// File: verification/core_bus_tb.sv
module core_bus_tb import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam bus_resp_t resp_okay = 2'b00;
    localparam bus_size_t size_word = 3'd2;
    localparam bus_burst_t burst_incr = 2'b01;
    localparam bus_addr_t timer_lo = 32'h0200_BFF8;
    localparam bus_addr_t timer_hi = 32'h0200_BFFC;
    localparam int num_txn = 20 + 20 + 32 + 7 + 60;    // the concurrent test counts as 60.

    logic clock, rst_n;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready, fetch_rlast;
    bus_addr_t fetch_araddr;
    bus_len_t fetch_arlen;
    bus_size_t fetch_arsize;
    bus_burst_t fetch_arburst;
    bus_data_t fetch_rdata;
    bus_resp_t fetch_rresp;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready, lsu_rlast;
    bus_addr_t lsu_araddr, lsu_awaddr;
    bus_size_t lsu_arsize, lsu_awsize;
    bus_data_t lsu_rdata, lsu_wdata;
    bus_resp_t lsu_rresp, lsu_bresp;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    bus_strb_t lsu_wstrb;
    logic m_axi_arvalid, m_axi_arready, m_axi_rvalid, m_axi_rready, m_axi_rlast;
    bus_addr_t m_axi_araddr, m_axi_awaddr;
    bus_len_t m_axi_arlen;
    bus_size_t m_axi_arsize, m_axi_awsize;
    bus_burst_t m_axi_arburst;
    bus_data_t m_axi_rdata, m_axi_wdata;
    bus_resp_t m_axi_rresp, m_axi_bresp;
    logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_wlast;
    logic m_axi_bvalid, m_axi_bready;
    bus_strb_t m_axi_wstrb;

    bus_data_t mem [bus_addr_t];
    int cyc = 0;
    int errors = 0, checks = 0, tests = 0, test_errors = 0;
    int ar_count = 0, aw_count = 0, w_count = 0;
    int fetch_rise = 0, lsu_rise = 0, prev_cyc = 0;
    logic have_prev = 1'b0;
    logic fetch_busy = 1'b0;
    logic lsu_busy = 1'b0;
    logic last_wlast;
    bus_addr_t last_awaddr;
    rd_owner_e prev_own;

    core_bus_top core_bus_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) cyc <= cyc + 1;

    function automatic bus_data_t mem_word(input bus_addr_t addr);
        bus_addr_t a;
        a = {addr[31:2], 2'b00};
        if (mem.exists(a)) return mem[a];
        return a ^ 32'h5A5A_5A5A;    // unwritten words follow the whole address.
    endfunction

    function automatic bus_data_t merge_bytes(input bus_data_t old, input bus_data_t d,
                                              input bus_strb_t strb);
        bus_data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    function automatic bus_addr_t rand_addr();
        return 32'h8000_0000 | ($urandom & 32'h000F_FFFC);
    endfunction

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input bus_size_t got, input bus_size_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input bus_burst_t got,
                               input bus_burst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail_check(input string what);
        checks++;
        errors++;
        $display("%s", what);
    endtask

    // every caller sits 10 ns after a rising edge and is left there again.
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // AXI read slave, one read at a time.
    initial begin
        bus_addr_t addr;
        bus_len_t len;
        m_axi_arready = 1'b0;
        m_axi_rvalid = 1'b0;
        m_axi_rdata = '0;
        m_axi_rresp = resp_okay;
        m_axi_rlast = 1'b0;
        forever begin
            do @(posedge clock); while (!m_axi_arvalid);
            #10;
            wait_cycles($urandom_range(0, 3));
            m_axi_arready = 1'b1;
            @(posedge clock);
            addr = m_axi_araddr;
            len = m_axi_arlen;
            check_size("m_axi_arsize", m_axi_arsize, size_word);
            check_burst("m_axi_arburst", m_axi_arburst, burst_incr);
            ar_count++;
            #10 m_axi_arready = 1'b0;
            for (int b = 0; b <= len; b++) begin
                wait_cycles($urandom_range(0, 3));
                m_axi_rvalid = 1'b1;
                m_axi_rdata = mem_word(addr + 4 * b);
                m_axi_rlast = (b == len);
                do @(posedge clock); while (!m_axi_rready);
                #10 m_axi_rvalid = 1'b0;
            end
        end
    end

    // AXI write slave, AW then W then B. Each ready stays up until the B handshake.
    initial begin
        bus_strb_t strb;
        bus_data_t d;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        m_axi_bvalid = 1'b0;
        m_axi_bresp = resp_okay;
        forever begin
            do @(posedge clock); while (!m_axi_awvalid);
            #10;
            wait_cycles($urandom_range(0, 3));
            m_axi_awready = 1'b1;
            @(posedge clock);
            last_awaddr = m_axi_awaddr;
            check_size("m_axi_awsize", m_axi_awsize, size_word);
            #10;
            do @(posedge clock); while (!m_axi_wvalid);
            #10;
            wait_cycles($urandom_range(0, 3));
            m_axi_wready = 1'b1;
            @(posedge clock);
            d = m_axi_wdata;
            strb = m_axi_wstrb;
            last_wlast = m_axi_wlast;
            #10;
            mem[{last_awaddr[31:2], 2'b00}] = merge_bytes(mem_word(last_awaddr), d, strb);
            wait_cycles($urandom_range(0, 3));
            m_axi_bvalid = 1'b1;
            do @(posedge clock); while (!m_axi_bready);
            #10 m_axi_bvalid = 1'b0;
            m_axi_awready = 1'b0;
            m_axi_wready = 1'b0;
        end
    end

    // every AW and W handshake counts, also a second copy of the same write.
    always @(posedge clock) begin
        if (m_axi_awvalid && m_axi_awready) aw_count++;
        if (m_axi_wvalid && m_axi_wready) w_count++;
    end

    // a response beat may only be offered to a client that waits for one.
    always @(posedge clock) begin
        if (rst_n && fetch_rvalid && !fetch_busy)
            fail_check("fetch_rvalid was high with no fetch read in flight");
        if (rst_n && lsu_rvalid && !lsu_busy)
            fail_check("lsu_rvalid was high with no load in flight");
    end

    // a requester that waited through the previous grant must win the next one.
    always @(posedge clock) begin
        if (rst_n && fetch_arvalid && fetch_arready) begin
            if (have_prev && prev_own == own_fetch && lsu_arvalid && lsu_rise <= prev_cyc + 1)
                fail_check("fetch was granted twice in a row while a load waited");
            prev_own = own_fetch;
            prev_cyc = cyc;
            have_prev = 1'b1;
        end
        if (rst_n && lsu_arvalid && lsu_arready) begin
            if (have_prev && prev_own == own_lsu && fetch_arvalid && fetch_rise <= prev_cyc + 1)
                fail_check("load was granted twice in a row while a fetch waited");
            prev_own = own_lsu;
            prev_cyc = cyc;
            have_prev = 1'b1;
        end
    end

    task automatic do_fetch(input bus_addr_t addr, input bus_len_t len);
        int beat;
        logic done;
        beat = 0;
        done = 1'b0;
        fetch_arvalid = 1'b1;
        fetch_araddr = addr;
        fetch_arlen = len;
        fetch_rise = cyc;
        do @(posedge clock); while (!fetch_arready);
        #10 fetch_arvalid = 1'b0;
        fetch_busy = 1'b1;
        while (!done) begin
            fetch_rready = ($urandom_range(0, 3) != 0);
            @(posedge clock);
            if (fetch_rvalid && fetch_rready) begin
                check_data("fetch_rdata", fetch_rdata, mem_word(addr + 4 * beat));
                check_resp("fetch_rresp", fetch_rresp, resp_okay);
                check_flag("fetch_rlast", fetch_rlast, beat == len);
                done = fetch_rlast || (beat == len);
                beat++;
            end
            #10;
        end
        fetch_rready = 1'b0;
        fetch_busy = 1'b0;
    endtask

    task automatic do_load(input bus_addr_t addr, output bus_data_t data, output int hs_cyc);
        logic done;
        done = 1'b0;
        lsu_arvalid = 1'b1;
        lsu_araddr = addr;
        lsu_rise = cyc;
        do @(posedge clock); while (!lsu_arready);
        hs_cyc = cyc;
        #10 lsu_arvalid = 1'b0;
        lsu_busy = 1'b1;
        while (!done) begin
            lsu_rready = ($urandom_range(0, 3) != 0);
            @(posedge clock);
            if (lsu_rvalid && lsu_rready) begin
                data = lsu_rdata;
                check_resp("lsu_rresp", lsu_rresp, resp_okay);
                check_flag("lsu_rlast", lsu_rlast, 1'b1);
                done = 1'b1;
            end
            #10;
        end
        lsu_rready = 1'b0;
        lsu_busy = 1'b0;
    endtask

    // both valids stay up until B, so the channel must hold back a second copy.
    task automatic do_write(input bus_addr_t addr, input bus_data_t d, input bus_strb_t strb);
        logic b_done;
        int aw_acks;
        int w_acks;
        b_done = 1'b0;
        aw_acks = 0;
        w_acks = 0;
        lsu_awvalid = 1'b1;
        lsu_awaddr = addr;
        lsu_wvalid = 1'b1;
        lsu_wdata = d;
        lsu_wstrb = strb;
        while (!b_done) begin
            lsu_bready = ($urandom_range(0, 3) != 0);
            @(posedge clock);
            if (lsu_awvalid && lsu_awready) aw_acks++;
            if (lsu_wvalid && lsu_wready) w_acks++;
            if (lsu_bvalid && lsu_bready) begin
                check_resp("lsu_bresp", lsu_bresp, resp_okay);
                b_done = 1'b1;
            end
            #10;
        end
        lsu_awvalid = 1'b0;
        lsu_wvalid = 1'b0;
        lsu_bready = 1'b0;
        if (aw_acks != 1 || w_acks != 1)
            fail_check("the write channel did not accept AW and W exactly once");
    endtask

    initial begin
        repeat (num_txn * 40) @(posedge clock);
        $display("timeout: the tests did not finish in %0d cycles", num_txn * 40);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        bus_addr_t a;
        bus_data_t d, got, v0, v1, exp;
        bus_strb_t s;
        int c0, c1, aw0, w0, ar0, stop;
        void'($urandom(32'heb28_46f1));
        rst_n = 1'b0;
        fetch_arvalid = 1'b0;
        fetch_araddr = '0;
        fetch_arlen = '0;
        fetch_arsize = size_word;
        fetch_arburst = burst_incr;
        fetch_rready = 1'b0;
        lsu_arvalid = 1'b0;
        lsu_araddr = '0;
        lsu_arsize = size_word;
        lsu_rready = 1'b0;
        lsu_awvalid = 1'b0;
        lsu_awaddr = '0;
        lsu_awsize = size_word;
        lsu_wvalid = 1'b0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        lsu_bready = 1'b0;
        repeat (4) @(posedge clock);
        #10 rst_n = 1'b1;

        for (int i = 0; i < 20; i++) do_fetch(rand_addr(), $urandom_range(0, 7));
        end_test("fetch bursts");

        for (int i = 0; i < 20; i++) begin
            a = rand_addr();
            do_load(a, got, c0);
            check_data("lsu_rdata", got, mem_word(a));
        end
        end_test("load reads");

        for (int i = 0; i < 16; i++) begin
            a = rand_addr();
            d = $urandom;
            s = $urandom_range(1, 15);
            exp = merge_bytes(mem_word(a), d, s);
            aw0 = aw_count;
            w0 = w_count;
            do_write(a, d, s);
            if (aw_count != aw0 + 1 || w_count != w0 + 1)
                fail_check("a write did not appear exactly once on AW and on W");
            check_flag("m_axi_wlast", last_wlast, 1'b1);
            check_data("m_axi_awaddr", last_awaddr, a);
            do_load(a, got, c0);
            check_data("lsu_rdata", got, exp);
        end
        end_test("writes");

        stop = cyc + 200;
        fork
            while (cyc < stop) begin
                wait_cycles($urandom_range(0, 3));
                do_fetch(rand_addr(), $urandom_range(0, 7));
            end
            while (cyc < stop) begin
                wait_cycles($urandom_range(0, 3));
                a = rand_addr();
                do_load(a, got, c0);
                check_data("lsu_rdata", got, mem_word(a));
            end
        join
        end_test("concurrent reads");

        ar0 = ar_count;
        do_load(timer_lo, v0, c0);
        for (int i = 0; i < 5; i++) begin
            wait_cycles($urandom_range(0, 5));
            do_load(timer_lo, v1, c1);
            if (!(v1 > v0 && v1 - v0 <= c1 - c0))
                fail_check("timer low half did not advance with the clock");
            v0 = v1;
            c0 = c1;
        end
        do_load(timer_hi, got, c1);
        check_data("lsu_rdata", got, 32'h0);
        if (ar_count != ar0) fail_check("a timer read went out on the AXI AR channel");
        end_test("timer reads");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/bus_pkg.sv
common/rd_req_if.sv
common/rd_rsp_if.sv
hw/read_arbiter.sv
hw/read_router.sv
hw/clint/clint_timer.sv
hw/write_channel.sv
hw/core_bus_top.sv
verification/core_bus_properties.sv
verification/core_bus_tb.sv
